/* common/mips_defines.svh */
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// Data path width
`define MIPS_XLEN 32

// Register number width, 32 general registers
`define MIPS_REG_AW 5

// Free-running cop0 count
`define MIPS_COUNT_W 32

`endif

/* common/mips_pkg.sv */
`include "mips_defines.svh"

package mips_pkg;

    // Three views of the same instruction word
    typedef struct packed {
        logic [5:0]              opcode;
        logic [`MIPS_REG_AW-1:0] rs;
        logic [`MIPS_REG_AW-1:0] rt;
        logic [`MIPS_REG_AW-1:0] rd;
        logic [4:0]              shamt;
        logic [5:0]              funct;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]              opcode;
        logic [`MIPS_REG_AW-1:0] rs;
        logic [`MIPS_REG_AW-1:0] rt;
        logic [15:0]             imm;
    } i_fields_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target;
    } j_fields_t;

    typedef union packed {
        r_fields_t r_fields;
        i_fields_t i_fields;
        j_fields_t j_fields;
    } instr_u;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor,
        alu_slt, alu_sll, alu_srl, alu_lui, alu_pass
    } alu_op_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    reg_dst;    // Destination is rd, not rt
        logic    alu_imm;    // Second operand from imm_ext
        logic    sign_ext;
        logic    mem_read;
        logic    mem_write;
        logic    branch;
        logic    jump;
        logic    write_reg;
        logic    write_hi;
        logic    write_lo;
        logic    mfc0;
        logic    mtc0;
    } control_t;

    typedef struct packed {
        logic                  valid;
        logic [`MIPS_XLEN-1:0] pc;
        instr_u                instr;
    } fetch_t;

    typedef struct packed {
        logic                    write_reg;
        logic [`MIPS_REG_AW-1:0] dest_reg;
        logic [`MIPS_XLEN-1:0]   dest_reg_data;
        logic                    write_hi;
        logic                    write_lo;
        logic [`MIPS_XLEN-1:0]   hi_data;
        logic [`MIPS_XLEN-1:0]   lo_data;
        logic                    write_cop0;
        logic [`MIPS_REG_AW-1:0] cop0_rd;
        logic [2:0]              cop0_sel;
        logic [`MIPS_XLEN-1:0]   cop0_data;
    } writeback_t;

    typedef enum logic [1:0] {fwd_none, fwd_ex, fwd_mem, fwd_wb} fwd_sel_e;

    // Result on its way through one later stage
    typedef struct packed {
        logic                    valid;
        logic [`MIPS_REG_AW-1:0] dest;
        logic [`MIPS_XLEN-1:0]   data;
    } fwd_src_t;

    typedef struct packed {
        fwd_sel_e rs_sel;
        fwd_sel_e rt_sel;
    } forward_info_t;

    typedef struct packed {
        logic                    valid;
        control_t                control;
        instr_u                  instr;
        logic [`MIPS_XLEN-1:0]   pc;
        logic [`MIPS_XLEN-1:0]   pcadd4;
        logic [`MIPS_XLEN-1:0]   pcjump;
        logic [`MIPS_XLEN-1:0]   rs;
        logic [`MIPS_XLEN-1:0]   rt;
        logic [`MIPS_XLEN-1:0]   imm_ext;
        logic [`MIPS_XLEN-1:0]   hi;
        logic [`MIPS_XLEN-1:0]   lo;
        logic [`MIPS_XLEN-1:0]   cop0;
        logic [`MIPS_REG_AW-1:0] dest_rd;
        logic [`MIPS_REG_AW-1:0] dest_cop0_rd;
        logic [2:0]              dest_cop0_sel;
    } decode_out_t;

endpackage

/* decode/main_decoder.sv */
`timescale 1ns/1ps

module main_decoder (
    input  mips_pkg::instr_u   instr,
    output mips_pkg::control_t ctl
);

    localparam logic [5:0] op_special = 6'b000000;
    localparam logic [5:0] op_j       = 6'b000010;
    localparam logic [5:0] op_jal     = 6'b000011;
    localparam logic [5:0] op_beq     = 6'b000100;
    localparam logic [5:0] op_addiu   = 6'b001001;
    localparam logic [5:0] op_andi    = 6'b001100;
    localparam logic [5:0] op_ori     = 6'b001101;
    localparam logic [5:0] op_lui     = 6'b001111;
    localparam logic [5:0] op_cop0    = 6'b010000;
    localparam logic [5:0] op_lw      = 6'b100011;
    localparam logic [5:0] op_sw      = 6'b101011;

    // Register-register ALU op writing rd
    function automatic mips_pkg::control_t rtype(input mips_pkg::alu_op_e op);
        return '{alu_op: op, reg_dst: 1'b1, write_reg: 1'b1, default: 1'b0};
    endfunction

    // Immediate ALU op writing rt
    function automatic mips_pkg::control_t itype(input mips_pkg::alu_op_e op, input logic sext);
        return '{alu_op: op, alu_imm: 1'b1, sign_ext: sext, write_reg: 1'b1, default: 1'b0};
    endfunction

    always_comb begin
        ctl = '0;   // Unknown encodings fall through as a bubble
        case (instr.r_fields.opcode)
            op_special: begin
                case (instr.r_fields.funct)
                    6'b100001: ctl = rtype(mips_pkg::alu_add);   // addu
                    6'b100011: ctl = rtype(mips_pkg::alu_sub);   // subu
                    6'b100100: ctl = rtype(mips_pkg::alu_and);
                    6'b100101: ctl = rtype(mips_pkg::alu_or);
                    6'b100110: ctl = rtype(mips_pkg::alu_xor);
                    6'b101010: ctl = rtype(mips_pkg::alu_slt);
                    6'b000000: ctl = rtype(mips_pkg::alu_sll);
                    6'b000010: ctl = rtype(mips_pkg::alu_srl);
                    6'b010001: ctl = '{alu_op: mips_pkg::alu_pass, write_hi: 1'b1, default: 1'b0};
                    6'b010011: ctl = '{alu_op: mips_pkg::alu_pass, write_lo: 1'b1, default: 1'b0};
                    default:   ctl = '0;
                endcase
            end
            op_addiu: ctl = itype(mips_pkg::alu_add, 1'b1);
            op_andi:  ctl = itype(mips_pkg::alu_and, 1'b0);
            op_ori:   ctl = itype(mips_pkg::alu_or, 1'b0);
            op_lui:   ctl = itype(mips_pkg::alu_lui, 1'b0);
            op_lw: begin
                ctl          = itype(mips_pkg::alu_add, 1'b1);
                ctl.mem_read = 1'b1;
            end
            op_sw: ctl = '{alu_op: mips_pkg::alu_add, alu_imm: 1'b1, sign_ext: 1'b1,
                           mem_write: 1'b1, default: 1'b0};
            op_beq: ctl = '{alu_op: mips_pkg::alu_sub, sign_ext: 1'b1, branch: 1'b1,
                            default: 1'b0};
            op_j:   ctl = '{alu_op: mips_pkg::alu_pass, jump: 1'b1, default: 1'b0};
            op_jal: ctl = '{alu_op: mips_pkg::alu_pass, jump: 1'b1, write_reg: 1'b1,
                            default: 1'b0};
            op_cop0: begin
                // rs field tells mfc0 from mtc0
                if (instr.r_fields.rs == 5'b00000)
                    ctl = '{alu_op: mips_pkg::alu_pass, mfc0: 1'b1, write_reg: 1'b1,
                            default: 1'b0};
                else if (instr.r_fields.rs == 5'b00100)
                    ctl = '{alu_op: mips_pkg::alu_pass, mtc0: 1'b1, default: 1'b0};
            end
            default: ctl = '0;
        endcase
    end

endmodule

/* decode/register_file.sv */
`timescale 1ns/1ps
`include "mips_defines.svh"

module register_file #(
    parameter int ADDR_W = `MIPS_REG_AW,
    parameter int DATA_W = `MIPS_XLEN
) (
    input  logic              pif,
    input  logic              rst,
    input  logic              we,
    input  logic [ADDR_W-1:0] waddr,
    input  logic [DATA_W-1:0] din,
    input  logic [ADDR_W-1:0] raddr_a,
    input  logic [ADDR_W-1:0] raddr_b,
    output logic [DATA_W-1:0] dout_a,
    output logic [DATA_W-1:0] dout_b
);

    logic [DATA_W-1:0] regs [2**ADDR_W];

    always_ff @(posedge pif) begin
        if (rst) begin
            for (int i = 0; i < 2**ADDR_W; i++) regs[i] <= '0;
        end else if (we && waddr != '0) begin   // r0 is hardwired
            regs[waddr] <= din;
        end
    end

    // Asynchronous read, no write bypass
    assign dout_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign dout_b = (raddr_b == '0) ? '0 : regs[raddr_b];

    a_r0_const: assert property (@(posedge pif) disable iff (rst)
        we && waddr == '0 |=> $stable(regs[0]));

endmodule

/* decode/register_cop0.sv */
`timescale 1ns/1ps
`include "mips_defines.svh"

module register_cop0 (
    input  logic                    pif,
    input  logic                    rst,
    input  logic                    we,
    input  logic [`MIPS_REG_AW-1:0] write_rd,
    input  logic [2:0]              write_sel,
    input  logic [`MIPS_XLEN-1:0]   din,
    input  logic [`MIPS_REG_AW-1:0] read_rd,
    input  logic [2:0]              read_sel,
    output logic [`MIPS_XLEN-1:0]   dout,
    output logic                    count_overflow
);

    localparam logic [`MIPS_REG_AW-1:0] reg_count   = 5'd9;
    localparam logic [`MIPS_REG_AW-1:0] reg_compare = 5'd11;
    localparam logic [`MIPS_REG_AW-1:0] reg_status  = 5'd12;
    localparam logic [`MIPS_REG_AW-1:0] reg_epc     = 5'd14;

    logic [`MIPS_COUNT_W-1:0] count_q;
    logic [`MIPS_XLEN-1:0]    compare_q;
    logic [`MIPS_XLEN-1:0]    status_q;
    logic [`MIPS_XLEN-1:0]    epc_q;
    logic                     count_we;
    logic                     overflow_q;

    assign count_we = we && write_sel == 3'd0 && write_rd == reg_count;

    always_ff @(posedge pif) begin
        if (rst) begin
            count_q    <= '0;
            compare_q  <= '0;
            status_q   <= '0;
            epc_q      <= '0;
            overflow_q <= 1'b0;
        end else begin
            // A write to count overrides the increment
            count_q    <= count_we ? din[`MIPS_COUNT_W-1:0] : count_q + 1'b1;
            overflow_q <= !count_we && (&count_q);   // Wrapping this edge
            if (we && write_sel == 3'd0) begin
                case (write_rd)
                    reg_compare: compare_q <= din;
                    reg_status:  status_q  <= din;
                    reg_epc:     epc_q     <= din;
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        dout = '0;
        if (read_sel == 3'd0) begin
            case (read_rd)
                reg_count:   dout = `MIPS_XLEN'(count_q);
                reg_compare: dout = compare_q;
                reg_status:  dout = status_q;
                reg_epc:     dout = epc_q;
                default:     dout = '0;
            endcase
        end
    end

    assign count_overflow = overflow_q;

endmodule

/* decode/stage_decode.sv */
`timescale 1ns/1ps
`include "mips_defines.svh"

module stage_decode (
    input  logic                    pif,
    input  logic                    rst,
    input  mips_pkg::fetch_t        fetch,
    input  mips_pkg::writeback_t    wb,
    input  logic                    stall,
    input  logic                    flush,
    input  mips_pkg::forward_info_t forward,
    input  mips_pkg::fwd_src_t      ex_src,
    input  mips_pkg::fwd_src_t      mem_src,
    input  mips_pkg::fwd_src_t      wb_src,
    output logic [`MIPS_REG_AW-1:0] rs,
    output logic [`MIPS_REG_AW-1:0] rt,
    output mips_pkg::decode_out_t   dout,
    output logic                    count_overflow
);

    logic                  valid_q;
    logic [`MIPS_XLEN-1:0] pc_q;
    mips_pkg::instr_u      instr_q;
    logic [`MIPS_XLEN-1:0] hi_q;
    logic [`MIPS_XLEN-1:0] lo_q;
    mips_pkg::control_t    ctl;
    logic [`MIPS_XLEN-1:0] rs_data;
    logic [`MIPS_XLEN-1:0] rt_data;
    logic [`MIPS_XLEN-1:0] cop0_data;
    logic [`MIPS_XLEN-1:0] pcadd4;
    logic [15:0]           imm;

    // Picks the newest copy of an operand
    function automatic logic [`MIPS_XLEN-1:0] fwd_mux(
        input mips_pkg::fwd_sel_e    sel,
        input logic [`MIPS_XLEN-1:0] rf_data
    );
        case (sel)
            mips_pkg::fwd_ex:  return ex_src.data;
            mips_pkg::fwd_mem: return mem_src.data;
            mips_pkg::fwd_wb:  return wb_src.data;
            default:           return rf_data;
        endcase
    endfunction

    // Input latch, flush wins over stall
    always_ff @(posedge pif) begin
        if (rst) begin
            valid_q <= 1'b0;
            pc_q    <= '0;
            instr_q <= '0;
        end else if (flush) begin
            valid_q <= 1'b0;
        end else if (!stall) begin
            valid_q <= fetch.valid;
            if (fetch.valid) begin
                pc_q    <= fetch.pc;
                instr_q <= fetch.instr;
            end
        end
    end

    always_ff @(posedge pif) begin
        if (rst) begin
            hi_q <= '0;
            lo_q <= '0;
        end else begin
            if (wb.write_hi) hi_q <= wb.hi_data;
            if (wb.write_lo) lo_q <= wb.lo_data;
        end
    end

    assign rs     = instr_q.r_fields.rs;
    assign rt     = instr_q.r_fields.rt;
    assign imm    = instr_q.i_fields.imm;
    assign pcadd4 = pc_q + `MIPS_XLEN'd4;

    main_decoder u_decoder (.instr(instr_q), .ctl(ctl));

    register_file u_regs (
        .pif(pif), .rst(rst),
        .we(wb.write_reg), .waddr(wb.dest_reg), .din(wb.dest_reg_data),
        .raddr_a(rs), .raddr_b(rt),
        .dout_a(rs_data), .dout_b(rt_data)
    );

    register_cop0 u_cop0 (
        .pif(pif), .rst(rst),
        .we(wb.write_cop0), .write_rd(wb.cop0_rd), .write_sel(wb.cop0_sel),
        .din(wb.cop0_data),
        .read_rd(instr_q.r_fields.rd), .read_sel(instr_q.r_fields.funct[2:0]),
        .dout(cop0_data), .count_overflow(count_overflow)
    );

    always_comb begin
        dout         = '0;
        dout.valid   = valid_q;
        dout.control = valid_q ? ctl : '0;   // Bubbles carry no control
        dout.instr   = instr_q;
        dout.pc      = pc_q;
        dout.pcadd4  = pcadd4;
        dout.pcjump  = {pcadd4[31:28], instr_q.j_fields.target, 2'b00};
        dout.rs      = fwd_mux(forward.rs_sel, rs_data);
        dout.rt      = fwd_mux(forward.rt_sel, rt_data);
        dout.hi      = hi_q;
        dout.lo      = lo_q;
        dout.cop0    = cop0_data;
        if (ctl.alu_op == mips_pkg::alu_lui)
            dout.imm_ext = {imm, 16'h0000};
        else if (ctl.sign_ext)
            dout.imm_ext = {{16{imm[15]}}, imm};
        else
            dout.imm_ext = {16'h0000, imm};
        // jal links through r31
        if (ctl.jump && ctl.write_reg)
            dout.dest_rd = 5'd31;
        else
            dout.dest_rd = ctl.reg_dst ? instr_q.r_fields.rd : rt;
        dout.dest_cop0_rd  = instr_q.r_fields.rd;
        dout.dest_cop0_sel = instr_q.r_fields.funct[2:0];
    end

    // Latched instruction must not move while held
    a_stall_hold: assert property (@(posedge pif) disable iff (rst)
        stall && !flush |=> $stable({dout.valid, dout.pc, dout.instr, dout.control}));

    // Forwarder result as seen by the stage, r0 is never forwarded
    a_rs_zero: assert property (@(posedge pif) disable iff (rst)
        rs == '0 |-> forward.rs_sel == mips_pkg::fwd_none);
    a_rt_zero: assert property (@(posedge pif) disable iff (rst)
        rt == '0 |-> forward.rt_sel == mips_pkg::fwd_none);

endmodule

/* hdl/main_forwarder.sv */
`timescale 1ns/1ps
`include "mips_defines.svh"

module main_forwarder (
    input  logic [`MIPS_REG_AW-1:0] rs,
    input  logic [`MIPS_REG_AW-1:0] rt,
    input  mips_pkg::fwd_src_t      ex_src,
    input  mips_pkg::fwd_src_t      mem_src,
    input  mips_pkg::fwd_src_t      wb_src,
    output mips_pkg::forward_info_t forward
);

    // Youngest matching stage wins
    function automatic mips_pkg::fwd_sel_e pick(input logic [`MIPS_REG_AW-1:0] op);
        if (op == '0)
            return mips_pkg::fwd_none;   // r0 is never forwarded
        if (ex_src.valid && ex_src.dest == op)
            return mips_pkg::fwd_ex;
        if (mem_src.valid && mem_src.dest == op)
            return mips_pkg::fwd_mem;
        if (wb_src.valid && wb_src.dest == op)
            return mips_pkg::fwd_wb;
        return mips_pkg::fwd_none;
    endfunction

    always_comb begin
        forward.rs_sel = pick(rs);
        forward.rt_sel = pick(rt);
    end

endmodule

/* hdl/decode_top.sv */
`timescale 1ns/1ps
`include "mips_defines.svh"

module decode_top (
    input  logic                  pif,
    input  logic                  rst,
    input  mips_pkg::fetch_t      fetch,
    input  mips_pkg::writeback_t  wb,
    input  mips_pkg::fwd_src_t    ex_src,
    input  mips_pkg::fwd_src_t    mem_src,
    input  mips_pkg::fwd_src_t    wb_src,
    input  logic                  stall,
    input  logic                  flush,
    output mips_pkg::decode_out_t dout,
    output logic                  count_overflow
);

    logic [`MIPS_REG_AW-1:0] rs;
    logic [`MIPS_REG_AW-1:0] rt;
    mips_pkg::forward_info_t forward;

    main_forwarder u_forwarder (
        .rs(rs), .rt(rt),
        .ex_src(ex_src), .mem_src(mem_src), .wb_src(wb_src),
        .forward(forward)
    );

    // Source data goes straight to the stage muxes
    stage_decode u_stage (
        .pif(pif), .rst(rst),
        .fetch(fetch), .wb(wb),
        .stall(stall), .flush(flush),
        .forward(forward),
        .ex_src(ex_src), .mem_src(mem_src), .wb_src(wb_src),
        .rs(rs), .rt(rt),
        .dout(dout), .count_overflow(count_overflow)
    );

endmodule

/* dv/decode_tb.sv */
`timescale 1ns/1ps
`include "mips_defines.svh"

module decode_tb;

    // Scheduled cycles per test group
    localparam int reset_cycles   = 4;
    localparam int decode_cycles  = 4 * (11 + 12);
    localparam int regs_cycles    = 36;
    localparam int fwd_cycles     = 40;
    localparam int special_cycles = 16;
    localparam int pipe_cycles    = 14;
    localparam int count_cycles   = 12;
    localparam int total_cycles   = reset_cycles + decode_cycles + regs_cycles + fwd_cycles
                                    + special_cycles + pipe_cycles + count_cycles;
    localparam int timeout_cycles = 4 * total_cycles;

    logic                  pif = 1'b0;
    logic                  rst;
    mips_pkg::fetch_t      fetch;
    mips_pkg::writeback_t  wb;
    mips_pkg::fwd_src_t    ex_src;
    mips_pkg::fwd_src_t    mem_src;
    mips_pkg::fwd_src_t    wb_src;
    logic                  stall;
    logic                  flush;
    mips_pkg::decode_out_t dout;
    logic                  count_overflow;

    integer seed   = 32'h1dd9;
    int     cycles = 0;

    // Shadow of the architectural state
    logic                  lat_valid;
    logic [`MIPS_XLEN-1:0] lat_pc;
    mips_pkg::instr_u      lat_instr;
    logic [`MIPS_XLEN-1:0] sh_regs [32];
    logic [`MIPS_XLEN-1:0] sh_hi;
    logic [`MIPS_XLEN-1:0] sh_lo;
    logic [`MIPS_XLEN-1:0] sh_count;
    logic [`MIPS_XLEN-1:0] sh_compare;
    logic [`MIPS_XLEN-1:0] sh_status;
    logic [`MIPS_XLEN-1:0] sh_epc;
    logic                  sh_ovf;

    always #50 pif = ~pif;

    decode_top decode_top_i (
        .pif(pif), .rst(rst), .fetch(fetch), .wb(wb),
        .ex_src(ex_src), .mem_src(mem_src), .wb_src(wb_src),
        .stall(stall), .flush(flush), .dout(dout), .count_overflow(count_overflow)
    );

    // Expected control word per opcode and funct
    function automatic mips_pkg::control_t ref_control(input mips_pkg::instr_u ins);
        mips_pkg::control_t c;
        c = '0;
        case (ins.r_fields.opcode)
            6'h00: begin
                case (ins.r_fields.funct)
                    6'h21: c = '{alu_op: mips_pkg::alu_add, reg_dst: 1, write_reg: 1, default: 0};
                    6'h23: c = '{alu_op: mips_pkg::alu_sub, reg_dst: 1, write_reg: 1, default: 0};
                    6'h24: c = '{alu_op: mips_pkg::alu_and, reg_dst: 1, write_reg: 1, default: 0};
                    6'h25: c = '{alu_op: mips_pkg::alu_or, reg_dst: 1, write_reg: 1, default: 0};
                    6'h26: c = '{alu_op: mips_pkg::alu_xor, reg_dst: 1, write_reg: 1, default: 0};
                    6'h2a: c = '{alu_op: mips_pkg::alu_slt, reg_dst: 1, write_reg: 1, default: 0};
                    6'h00: c = '{alu_op: mips_pkg::alu_sll, reg_dst: 1, write_reg: 1, default: 0};
                    6'h02: c = '{alu_op: mips_pkg::alu_srl, reg_dst: 1, write_reg: 1, default: 0};
                    6'h11: c = '{alu_op: mips_pkg::alu_pass, write_hi: 1, default: 0};   // mthi
                    6'h13: c = '{alu_op: mips_pkg::alu_pass, write_lo: 1, default: 0};   // mtlo
                    default: c = '0;
                endcase
            end
            6'h09: c = '{alu_op: mips_pkg::alu_add, alu_imm: 1, sign_ext: 1, write_reg: 1,
                         default: 0};
            6'h0c: c = '{alu_op: mips_pkg::alu_and, alu_imm: 1, write_reg: 1, default: 0};
            6'h0d: c = '{alu_op: mips_pkg::alu_or, alu_imm: 1, write_reg: 1, default: 0};
            6'h0f: c = '{alu_op: mips_pkg::alu_lui, alu_imm: 1, write_reg: 1, default: 0};
            6'h23: c = '{alu_op: mips_pkg::alu_add, alu_imm: 1, sign_ext: 1, mem_read: 1,
                         write_reg: 1, default: 0};
            6'h2b: c = '{alu_op: mips_pkg::alu_add, alu_imm: 1, sign_ext: 1, mem_write: 1,
                         default: 0};
            6'h04: c = '{alu_op: mips_pkg::alu_sub, sign_ext: 1, branch: 1, default: 0};
            6'h02: c = '{alu_op: mips_pkg::alu_pass, jump: 1, default: 0};
            6'h03: c = '{alu_op: mips_pkg::alu_pass, jump: 1, write_reg: 1, default: 0};
            6'h10: begin
                if (ins.r_fields.rs == 5'd0)
                    c = '{alu_op: mips_pkg::alu_pass, mfc0: 1, write_reg: 1, default: 0};
                else if (ins.r_fields.rs == 5'd4)
                    c = '{alu_op: mips_pkg::alu_pass, mtc0: 1, default: 0};
            end
            default: c = '0;
        endcase
        return c;
    endfunction

    // Newest value of an operand, ex before mem before wb
    function automatic logic [`MIPS_XLEN-1:0] ref_operand(input logic [4:0] r);
        if (r == 5'd0)
            return '0;
        if (ex_src.valid && ex_src.dest == r)
            return ex_src.data;
        if (mem_src.valid && mem_src.dest == r)
            return mem_src.data;
        if (wb_src.valid && wb_src.dest == r)
            return wb_src.data;
        return sh_regs[r];
    endfunction

    function automatic logic [`MIPS_XLEN-1:0] ref_cop0(input logic [4:0] rd,
                                                      input logic [2:0] sel);
        if (sel != 3'd0)
            return '0;
        case (rd)
            5'd9:    return sh_count;
            5'd11:   return sh_compare;
            5'd12:   return sh_status;
            5'd14:   return sh_epc;
            default: return '0;
        endcase
    endfunction

    function automatic mips_pkg::decode_out_t ref_decode();
        mips_pkg::decode_out_t d;
        mips_pkg::control_t    c;
        logic [15:0]           imm;
        logic [`MIPS_XLEN-1:0] pc4;
        c   = ref_control(lat_instr);
        imm = lat_instr.i_fields.imm;
        pc4 = lat_pc + 32'd4;
        d           = '0;
        d.valid     = lat_valid;
        d.control   = lat_valid ? c : '0;
        d.instr     = lat_instr;
        d.pc        = lat_pc;
        d.pcadd4    = pc4;
        d.pcjump    = {pc4[31:28], lat_instr.j_fields.target, 2'b00};
        d.rs        = ref_operand(lat_instr.r_fields.rs);
        d.rt        = ref_operand(lat_instr.r_fields.rt);
        d.hi        = sh_hi;
        d.lo        = sh_lo;
        d.cop0      = ref_cop0(lat_instr.r_fields.rd, lat_instr.r_fields.funct[2:0]);
        if (lat_instr.r_fields.opcode == 6'h0f)
            d.imm_ext = {imm, 16'h0000};   // lui
        else if (c.sign_ext)
            d.imm_ext = {{16{imm[15]}}, imm};
        else
            d.imm_ext = {16'h0000, imm};
        if (lat_instr.r_fields.opcode == 6'h03)
            d.dest_rd = 5'd31;   // jal link register
        else
            d.dest_rd = c.reg_dst ? lat_instr.r_fields.rd : lat_instr.r_fields.rt;
        d.dest_cop0_rd  = lat_instr.r_fields.rd;
        d.dest_cop0_sel = lat_instr.r_fields.funct[2:0];
        return d;
    endfunction

    always @(posedge pif) begin : shadow_model
        logic count_write;
        count_write = wb.write_cop0 && wb.cop0_sel == 3'd0 && wb.cop0_rd == 5'd9;
        if (rst) begin
            lat_valid  <= 1'b0;
            lat_pc     <= '0;
            lat_instr  <= '0;
            for (int i = 0; i < 32; i++)
                sh_regs[i] <= '0;
            sh_hi      <= '0;
            sh_lo      <= '0;
            sh_count   <= '0;
            sh_compare <= '0;
            sh_status  <= '0;
            sh_epc     <= '0;
            sh_ovf     <= 1'b0;
        end else begin
            if (flush) begin
                lat_valid <= 1'b0;
            end else if (!stall) begin
                lat_valid <= fetch.valid;
                if (fetch.valid) begin
                    lat_pc    <= fetch.pc;
                    lat_instr <= fetch.instr;
                end
            end
            if (wb.write_reg && wb.dest_reg != 5'd0)
                sh_regs[wb.dest_reg] <= wb.dest_reg_data;
            if (wb.write_hi)
                sh_hi <= wb.hi_data;
            if (wb.write_lo)
                sh_lo <= wb.lo_data;
            if (wb.write_cop0 && wb.cop0_sel == 3'd0) begin
                if (wb.cop0_rd == 5'd11)
                    sh_compare <= wb.cop0_data;
                if (wb.cop0_rd == 5'd12)
                    sh_status <= wb.cop0_data;
                if (wb.cop0_rd == 5'd14)
                    sh_epc <= wb.cop0_data;
            end
            sh_count <= count_write ? wb.cop0_data : sh_count + 32'd1;
            sh_ovf   <= !count_write && sh_count == '1;   // Wraps at this edge
        end
    end

    task automatic check_decode(input mips_pkg::decode_out_t got,
                                input mips_pkg::decode_out_t exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t %s: got %h expected %h", $time, what, got, exp);
            $display("STATUS: FAIL");
            $fatal(1, "%s mismatch", what);
        end
    endtask

    task automatic check_overflow(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t %s: got %b expected %b", $time, what, got, exp);
            $display("STATUS: FAIL");
            $fatal(1, "%s mismatch", what);
        end
    endtask

    // Outputs are settled mid-cycle
    always @(negedge pif) begin
        if (!rst) begin
            check_decode(dout, ref_decode(), "decode output");
            check_overflow(count_overflow, sh_ovf, "count overflow");
        end
    end

    always @(posedge pif) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("STATUS: FAIL");
            $fatal(1, "timeout, tests did not finish");
        end
    end

    task automatic tick();
        @(posedge pif);
        #5;
        wb = '0;   // Write-back strobes last one cycle
    endtask

    task automatic send(input logic [`MIPS_XLEN-1:0] word);
        logic [`MIPS_XLEN-1:0] rnd;
        rnd         = $random(seed);
        fetch.valid = 1'b1;
        fetch.pc    = {rnd[31:2], 2'b00};
        fetch.instr = word;
        tick();
    endtask

    task automatic strobe_reg(input logic [4:0] r, input logic [`MIPS_XLEN-1:0] data);
        wb.write_reg     = 1'b1;
        wb.dest_reg      = r;
        wb.dest_reg_data = data;
    endtask

    task automatic strobe_cop0(input logic [4:0] rd, input logic [2:0] sel,
                               input logic [`MIPS_XLEN-1:0] data);
        wb.write_cop0 = 1'b1;
        wb.cop0_rd    = rd;
        wb.cop0_sel   = sel;
        wb.cop0_data  = data;
    endtask

    // mtc0 write-back, then mfc0 of the same register
    task automatic cop0_roundtrip(input logic [4:0] rd, input logic [2:0] sel);
        strobe_cop0(rd, sel, $random(seed));
        tick();
        send({6'h10, 5'd0, 5'd2, rd, 8'h00, sel});
    endtask

    function automatic mips_pkg::fwd_src_t rand_src(input logic [31:0] r1,
                                                    input logic [31:0] r2);
        return '{valid: r1[0], dest: {2'b00, r1[3:1]}, data: r2};
    endfunction

    initial begin : stimulus
        logic [`MIPS_XLEN-1:0] w;
        logic [`MIPS_XLEN-1:0] rnd;
        logic [5:0]            r_functs [11];
        logic [5:0]            i_ops [12];
        r_functs = '{6'h21, 6'h23, 6'h24, 6'h25, 6'h26, 6'h2a, 6'h00, 6'h02,
                     6'h11, 6'h13, 6'h3f};
        i_ops    = '{6'h09, 6'h0c, 6'h0d, 6'h0f, 6'h23, 6'h2b, 6'h04, 6'h02,
                     6'h03, 6'h10, 6'h10, 6'h3f};
        rst     = 1'b1;
        fetch   = '0;
        wb      = '0;
        ex_src  = '0;
        mem_src = '0;
        wb_src  = '0;
        stall   = 1'b0;
        flush   = 1'b0;
        repeat (reset_cycles) @(posedge pif);
        #5;
        rst = 1'b0;

        // Control decoding, R-type then the other opcodes
        for (int i = 0; i < 11; i++) begin
            for (int k = 0; k < 4; k++) begin
                w        = $random(seed);
                w[31:26] = 6'h00;
                w[5:0]   = r_functs[i];
                send(w);
            end
        end
        for (int i = 0; i < 12; i++) begin
            for (int k = 0; k < 4; k++) begin
                w        = $random(seed);
                w[31:26] = i_ops[i];
                if (i == 9)
                    w[25:21] = k[0] ? 5'd4 : 5'd0;   // mtc0 or mfc0
                if (i == 10)
                    w[25:21] = 5'd7;                 // Unused cop0 form
                send(w);
            end
        end

        // Register writes, then reads from the next cycle on
        for (int r = 0; r < 32; r++) begin
            strobe_reg(r[4:0], $random(seed));
            w        = $random(seed);
            w[31:26] = 6'h00;
            w[25:21] = r[4:0];
            w[20:16] = 5'(31 - r);
            w[5:0]   = 6'h21;
            send(w);
        end

        // Random later-stage sources on registers 0 to 7
        for (int n = 0; n < fwd_cycles; n++) begin
            ex_src   = rand_src($random(seed), $random(seed));
            mem_src  = rand_src($random(seed), $random(seed));
            wb_src   = rand_src($random(seed), $random(seed));
            rnd      = $random(seed);
            strobe_reg({2'b00, rnd[2:0]}, $random(seed));
            w        = $random(seed);
            w[31:26] = 6'h00;
            w[25:24] = 2'b00;
            w[20:19] = 2'b00;
            w[5:0]   = 6'h21;
            send(w);
        end
        ex_src  = '0;
        mem_src = '0;
        wb_src  = '0;

        // hi and lo from write-back, cop0 through mfc0
        for (int n = 0; n < 4; n++) begin
            wb.write_hi = 1'b1;
            wb.hi_data  = $random(seed);
            wb.write_lo = n[0];
            wb.lo_data  = $random(seed);
            send({6'h00, 5'(n + 1), 15'h0000, 6'h11});
        end
        cop0_roundtrip(5'd12, 3'd0);
        cop0_roundtrip(5'd14, 3'd0);
        cop0_roundtrip(5'd11, 3'd0);
        cop0_roundtrip(5'd12, 3'd1);   // Other sel leaves status alone
        send({6'h10, 5'd0, 5'd2, 5'd12, 8'h00, 3'd0});

        // Stall, flush during stall, then plain flush
        send({6'h00, 5'd1, 5'd2, 5'd3, 5'd0, 6'h21});
        stall = 1'b1;
        for (int n = 0; n < 3; n++)
            send($random(seed));
        flush = 1'b1;
        tick();
        flush = 1'b0;
        tick();
        stall = 1'b0;
        send($random(seed));
        flush = 1'b1;
        tick();
        flush = 1'b0;
        fetch.valid = 1'b0;
        tick();

        // Count loaded near the top wraps after four edges
        strobe_cop0(5'd9, 3'd0, 32'hffff_fffc);
        tick();
        for (int k = 0; k < 6; k++) begin
            @(negedge pif);
            check_overflow(count_overflow, k == 4, "count wrap pulse");
        end
        tick();
        send({6'h10, 5'd0, 5'd2, 5'd9, 8'h00, 3'd0});
        fetch.valid = 1'b0;
        tick();
        @(negedge pif);
        #1;
        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* sim.f */
+incdir+common
common/mips_pkg.sv
decode/main_decoder.sv
decode/register_file.sv
decode/register_cop0.sv
decode/stage_decode.sv
hdl/main_forwarder.sv
hdl/decode_top.sv
dv/decode_tb.sv

/* Makefile */
# Verilator flow for the decode stage

VERILATOR ?= verilator
TOP       ?= decode_tb
DUT_TOP   ?= decode_top
FLIST     ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing
PASS_TEXT ?= STATUS: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# Pass only when the testbench prints its pass line
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FLIST) --top-module $(DUT_TOP)

clean:
	rm -rf $(BUILD_DIR)
